// ==== design/fetch_pkg.sv ====
`default_nettype none

package fetch_pkg;

    typedef logic [31:0] addr_t;
    typedef logic [31:0] inst_t;

    localparam addr_t RESET_PC = 32'h3000_0000;

    localparam int LINE_WORDS = 4;
    localparam int LINE_BYTES = 4 * LINE_WORDS;

    // address split is tag | index | byte offset
    localparam int OFFSET_W = $clog2(LINE_BYTES);
    localparam int INDEX_W  = 4;
    localparam int TAG_W    = 32 - INDEX_W - OFFSET_W;

    // word 0 of the line sits in the low 32 bits
    typedef logic [LINE_WORDS*32-1:0] line_t;

    typedef struct packed {
        addr_t pc;
        inst_t inst;
        logic  fault;
    } fetch_out_t;

    typedef enum logic [1:0] {
        IDLE,
        MISS,
        FILL
    } fetch_state_t;

endpackage

`default_nettype wire

// ==== design/axi_rd_pkg.sv ====
`default_nettype none

package axi_rd_pkg;

    typedef struct packed {
        logic [31:0] addr;
        logic [3:0]  id;
        logic [7:0]  len;
        logic [2:0]  size;
        logic [1:0]  burst;
    } axi_ar_t;

    typedef struct packed {
        logic [31:0] data;
        logic [1:0]  resp;
        logic        last;
        logic [3:0]  id;
    } axi_r_t;

    localparam logic [1:0] BURST_FIXED = 2'b00;
    localparam logic [1:0] BURST_INCR  = 2'b01;

    localparam logic [1:0] RESP_OKAY = 2'b00;

    // four bytes per beat
    localparam logic [2:0] SIZE_WORD = 3'd2;

    // the SDRAM window covers A000_0000 up to BFFF_FFFF
    localparam logic [3:0] SDRAM_NIB_LO = 4'hA;
    localparam logic [3:0] SDRAM_NIB_HI = 4'hB;

endpackage

`default_nettype wire

// ==== design/pc_gen.sv ====
`default_nettype none

module pc_gen
    import fetch_pkg::*;
(
    input  wire        clk,
    input  wire        rst,
    input  wire        pc_update,
    input  wire        redirect_valid,
    input  wire addr_t redirect_pc,
    output addr_t      pc
);

    addr_t snpc;

    assign snpc = pc + 32'd4;

    // a redirect from execute wins over the sequential step, even while stalled
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            pc <= RESET_PC;
        end else if (redirect_valid) begin
            pc <= redirect_pc;
        end else if (pc_update) begin
            pc <= snpc;
        end
    end

    // execute only ever hands back word-aligned targets
    pc_aligned_a: assert property (
        @(posedge clk) disable iff (rst)
        pc[1:0] == 2'b00
    );

endmodule

`default_nettype wire

// ==== design/fetch_ctrl.sv ====
`default_nettype none

module fetch_ctrl
    import fetch_pkg::*;
(
    input  wire        clk,
    input  wire        rst,
    input  wire        idu_ready,
    input  wire        hit,
    input  wire        redirect_valid,
    input  wire        fill_valid,
    input  wire inst_t hit_inst,
    input  wire        hit_fault,
    input  wire addr_t pc,
    output logic       pc_update,
    output logic       refill_start,
    output logic       inst_valid,
    output fetch_out_t fetch_out
);

    fetch_state_t state;
    fetch_state_t next_state;
    logic         issue;
    logic         miss;

    assign issue = (state == IDLE) && idu_ready && hit;
    assign miss  = (state == IDLE) && idu_ready && !hit;

    always_comb begin
        next_state = state;
        case (state)
            IDLE: begin
                if (miss) begin
                    next_state = MISS;
                end
            end
            MISS: begin
                next_state = FILL;
            end
            FILL: begin
                if (fill_valid) begin
                    next_state = IDLE;
                end
            end
            default: begin
                next_state = IDLE;
            end
        endcase
    end

    // the pc only steps when an instruction is actually taken from the cache
    assign pc_update = issue;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state        <= IDLE;
            refill_start <= 1'b0;
            inst_valid   <= 1'b0;
        end else begin
            state        <= next_state;
            refill_start <= miss;
            // the slot is dropped when execute redirects in the same cycle
            inst_valid   <= issue && !redirect_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (issue) begin
            fetch_out.pc    <= pc;
            fetch_out.inst  <= hit_inst;
            fetch_out.fault <= hit_fault;
        end
    end

    refill_from_idle_a: assert property (
        @(posedge clk) disable iff (rst)
        refill_start |-> $past(state) == IDLE
    );

    // the refill engine must only answer a request that this FSM made
    no_fill_in_idle_a: assert property (
        @(posedge clk) disable iff (rst)
        fill_valid |-> state == FILL
    );

endmodule

`default_nettype wire

// ==== design/icache.sv ====
`default_nettype none

module icache
    import fetch_pkg::*;
(
    input  wire        clk,
    input  wire        rst,
    input  wire addr_t pc,
    input  wire        fill_valid,
    input  wire line_t fill_line,
    input  wire        fill_fault,
    output logic       hit,
    output inst_t      inst,
    output logic       fault
);

    localparam int LINES = 2 ** INDEX_W;

    logic [INDEX_W-1:0]    index;
    logic [TAG_W-1:0]      tag;
    logic [OFFSET_W-3:0]   word;
    line_t                 line_rd;

    logic [TAG_W-1:0]      tag_mem  [LINES];
    line_t                 line_mem [LINES];
    logic [LINES-1:0]      fault_mem;
    logic [LINES-1:0]      valid_q;

    assign index = pc[OFFSET_W +: INDEX_W];
    assign tag   = pc[OFFSET_W + INDEX_W +: TAG_W];
    assign word  = pc[OFFSET_W-1:2];

    assign line_rd = line_mem[index];
    assign hit     = valid_q[index] && (tag_mem[index] == tag);
    assign inst    = line_rd[{word, 5'd0} +: 32];
    // the fault flag covers the whole line, so every word of it reports it
    assign fault   = fault_mem[index];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            valid_q <= '0;
        end else if (fill_valid) begin
            valid_q[index] <= 1'b1;
        end
    end

    // the fill lands at the line the pc points to when the refill finishes
    always_ff @(posedge clk) begin
        if (fill_valid) begin
            tag_mem[index]   <= tag;
            line_mem[index]  <= fill_line;
            fault_mem[index] <= fill_fault;
        end
    end

endmodule

`default_nettype wire

// ==== design/axi_refill.sv ====
`default_nettype none

module axi_refill
    import fetch_pkg::*;
    import axi_rd_pkg::*;
(
    input  wire         clk,
    input  wire         rst,
    input  wire         refill_start,
    input  wire addr_t  pc,
    output axi_ar_t     ar,
    output logic        arvalid,
    input  wire         arready,
    input  wire axi_r_t r,
    input  wire         rvalid,
    output logic        rready,
    output logic        fill_valid,
    output line_t       fill_line,
    output logic        fill_fault
);

    localparam int BEAT_W = $clog2(LINE_WORDS);

    typedef enum logic [1:0] {
        RF_IDLE,
        RF_ADDR,
        RF_DATA
    } refill_state_t;

    refill_state_t     state;
    logic [BEAT_W-1:0] beat_cnt;
    addr_t             line_base;
    logic              in_sdram;
    logic              start;
    logic              ar_done;
    logic              r_done;
    logic              last_beat;
    logic              single;

    assign line_base = {pc[31:OFFSET_W], {OFFSET_W{1'b0}}};
    assign in_sdram  = (line_base[31:28] == SDRAM_NIB_LO) || (line_base[31:28] == SDRAM_NIB_HI);

    assign start   = (state == RF_IDLE) && refill_start;
    assign ar_done = arvalid && arready;
    assign r_done  = rvalid && rready;
    assign single  = (ar.burst == BURST_FIXED);

    // a burst ends on rlast, single reads end once the fourth word is back
    assign last_beat = single ? (beat_cnt == BEAT_W'(LINE_WORDS - 1)) : r.last;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state      <= RF_IDLE;
            arvalid    <= 1'b0;
            rready     <= 1'b0;
            fill_valid <= 1'b0;
            beat_cnt   <= '0;
        end else begin
            fill_valid <= 1'b0;
            case (state)
                RF_IDLE: begin
                    if (refill_start) begin
                        arvalid  <= 1'b1;
                        beat_cnt <= '0;
                        state    <= RF_ADDR;
                    end
                end
                RF_ADDR: begin
                    if (ar_done) begin
                        arvalid <= 1'b0;
                        rready  <= 1'b1;
                        state   <= RF_DATA;
                    end
                end
                RF_DATA: begin
                    if (r_done) begin
                        beat_cnt <= beat_cnt + 1'b1;
                        if (last_beat) begin
                            rready     <= 1'b0;
                            fill_valid <= 1'b1;
                            state      <= RF_IDLE;
                        end else if (single) begin
                            // next word needs its own request
                            rready  <= 1'b0;
                            arvalid <= 1'b1;
                            state   <= RF_ADDR;
                        end
                    end
                end
                default: begin
                    state <= RF_IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            ar.addr  <= line_base;
            ar.id    <= 4'd0;
            ar.len   <= in_sdram ? 8'(LINE_WORDS - 1) : 8'd0;
            ar.size  <= SIZE_WORD;
            ar.burst <= in_sdram ? BURST_INCR : BURST_FIXED;
        end else if (r_done && single && !last_beat) begin
            ar.addr <= ar.addr + 32'd4;
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            fill_fault <= 1'b0;
        end else if (r_done) begin
            fill_fault <= fill_fault || (r.resp != RESP_OKAY);
        end
        if (r_done) begin
            fill_line[{beat_cnt, 5'd0} +: 32] <= r.data;
        end
    end

    ar_stable_a: assert property (
        @(posedge clk) disable iff (rst)
        arvalid && !arready |=> arvalid && $stable(ar)
    );

endmodule

`default_nettype wire

// ==== design/ifu_top.sv ====
`default_nettype none

module ifu_top
    import fetch_pkg::*;
    import axi_rd_pkg::*;
(
    input  wire         clk,
    input  wire         rst,
    input  wire         redirect_valid,
    input  wire addr_t  redirect_pc,
    input  wire         idu_ready,
    output logic        inst_valid,
    output fetch_out_t  fetch_out,
    output axi_ar_t     ar,
    output logic        arvalid,
    input  wire         arready,
    input  wire axi_r_t r,
    input  wire         rvalid,
    output logic        rready
);

    addr_t pc;
    logic  pc_update;
    logic  refill_start;
    logic  hit;
    inst_t hit_inst;
    logic  hit_fault;
    logic  fill_valid;
    line_t fill_line;
    logic  fill_fault;

    pc_gen u_pc_gen (
        .clk            (clk),
        .rst            (rst),
        .pc_update      (pc_update),
        .redirect_valid (redirect_valid),
        .redirect_pc    (redirect_pc),
        .pc             (pc)
    );

    fetch_ctrl u_fetch_ctrl (
        .clk            (clk),
        .rst            (rst),
        .idu_ready      (idu_ready),
        .hit            (hit),
        .redirect_valid (redirect_valid),
        .fill_valid     (fill_valid),
        .hit_inst       (hit_inst),
        .hit_fault      (hit_fault),
        .pc             (pc),
        .pc_update      (pc_update),
        .refill_start   (refill_start),
        .inst_valid     (inst_valid),
        .fetch_out      (fetch_out)
    );

    icache u_icache (
        .clk        (clk),
        .rst        (rst),
        .pc         (pc),
        .fill_valid (fill_valid),
        .fill_line  (fill_line),
        .fill_fault (fill_fault),
        .hit        (hit),
        .inst       (hit_inst),
        .fault      (hit_fault)
    );

    axi_refill u_axi_refill (
        .clk          (clk),
        .rst          (rst),
        .refill_start (refill_start),
        .pc           (pc),
        .ar           (ar),
        .arvalid      (arvalid),
        .arready      (arready),
        .r            (r),
        .rvalid       (rvalid),
        .rready       (rready),
        .fill_valid   (fill_valid),
        .fill_line    (fill_line),
        .fill_fault   (fill_fault)
    );

endmodule

`default_nettype wire

// ==== verif/axi_mem_model.sv ====
`default_nettype none

module axi_mem_model
    import fetch_pkg::*;
    import axi_rd_pkg::*;
(
    input  wire          clk,
    input  wire          rst,
    input  wire axi_ar_t ar,
    input  wire          arvalid,
    output logic         arready,
    output axi_r_t       r,
    output logic         rvalid,
    input  wire          rready,
    output int           ar_count
);

    localparam logic [1:0] RESP_SLVERR = 2'b10;
    localparam addr_t      FAULT_LO    = 32'h3000_0100;
    localparam addr_t      FAULT_HI    = 32'h3000_010F;
    localparam logic [31:0] WORD_XOR   = 32'hA5A5_0000;

    logic [31:0] rng_state;
    logic [7:0]  len_log   [64];
    logic [1:0]  burst_log [64];
    logic [2:0]  size_log  [64];
    logic [3:0]  id_log    [64];

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // waits 0 to 3 cycles and returns just after a rising edge
    task automatic random_delay();
        rng_state = xorshift(rng_state);
        repeat (rng_state[1:0]) begin
            @(posedge clk);
            #1;
        end
    endtask

    // one transaction at a time, which is all the refill engine issues
    initial begin
        axi_ar_t req;
        addr_t   addr;
        int      beat;
        rng_state = 32'h2508_a89f;
        arready   = 1'b0;
        rvalid    = 1'b0;
        r         = '0;
        ar_count  = 0;
        forever begin
            @(posedge clk);
            if (!rst && arvalid) begin
                req = ar;
                #1;
                random_delay();
                arready = 1'b1;
                @(posedge clk);
                #1;
                arready             = 1'b0;
                len_log[ar_count]   = req.len;
                burst_log[ar_count] = req.burst;
                size_log[ar_count]  = req.size;
                id_log[ar_count]    = req.id;
                ar_count++;
                for (beat = 0; beat <= int'(req.len); beat++) begin
                    random_delay();
                    addr   = (req.burst == BURST_INCR) ? req.addr + 32'(4 * beat) : req.addr;
                    r.data = addr ^ WORD_XOR;
                    r.resp = (addr >= FAULT_LO && addr <= FAULT_HI) ? RESP_SLVERR : RESP_OKAY;
                    r.last = (beat == int'(req.len));
                    r.id   = 4'd0;
                    rvalid = 1'b1;
                    @(posedge clk);
                    while (!rready) begin
                        @(posedge clk);
                    end
                    #1;
                    rvalid = 1'b0;
                end
            end
        end
    end

endmodule

`default_nettype wire

// ==== verif/ifu_tb.sv ====
`default_nettype none

module ifu_tb
    import fetch_pkg::*;
    import axi_rd_pkg::*;
();

    // five refills of at most ~40 cycles and about forty hits stay under a
    // thousand cycles, so this limit only trips on a hang
    localparam int          TIMEOUT_CYCLES = 20000;
    localparam logic [31:0] WORD_XOR       = 32'hA5A5_0000;

    logic       clk;
    logic       rst;
    logic       redirect_valid;
    addr_t      redirect_pc;
    logic       idu_ready;
    logic       inst_valid;
    fetch_out_t fetch_out;
    axi_ar_t    ar;
    logic       arvalid;
    logic       arready;
    axi_r_t     r;
    logic       rvalid;
    logic       rready;
    int         ar_count;
    int         cycle_cnt;

    ifu_top DUT (.*);

    axi_mem_model slave (.*);

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    initial begin
        cycle_cnt = 0;
        while (cycle_cnt < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycle_cnt++;
        end
        $display("timeout: the tests did not finish within %0d cycles", TIMEOUT_CYCLES);
        $display(">>> FAIL");
        $fatal(1, "simulation timed out");
    end

    function automatic inst_t expected_inst(input addr_t pc);
        return pc ^ WORD_XOR;
    endfunction

    function automatic logic expected_fault(input addr_t pc);
        return (pc >= 32'h3000_0100) && (pc <= 32'h3000_010F);
    endfunction

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("** Error at %0t: %s = %h, expected %h", $time, name, got, exp);
            $display(">>> FAIL");
            $fatal(1, "mismatch on %s", name);
        end
    endtask

    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    task automatic redirect_to(input addr_t target);
        redirect_valid = 1'b1;
        redirect_pc    = target;
        next_cycle();
        redirect_valid = 1'b0;
    endtask

    // takes count instructions in order and then stalls decode at once,
    // so the pc never runs into the following line
    task automatic fetch_and_check(input addr_t first_pc, input int count);
        addr_t exp_pc;
        int    seen;
        exp_pc    = first_pc;
        seen      = 0;
        idu_ready = 1'b1;
        while (seen < count) begin
            next_cycle();
            if (inst_valid) begin
                check_value("fetch_out.pc", fetch_out.pc, exp_pc);
                check_value("fetch_out.inst", fetch_out.inst, expected_inst(exp_pc));
                check_value("fetch_out.fault", 32'(fetch_out.fault),
                            32'(expected_fault(exp_pc)));
                exp_pc = exp_pc + 32'd4;
                seen++;
            end
        end
        idu_ready = 1'b0;
    endtask

    task automatic check_requests(input int first, input int count,
                                  input logic [7:0] len, input logic [1:0] burst);
        int i;
        check_value("ar_count", 32'(ar_count), 32'(first + count));
        for (i = first; i < first + count; i++) begin
            check_value("ar.len", 32'(slave.len_log[i]), 32'(len));
            check_value("ar.burst", 32'(slave.burst_log[i]), 32'(burst));
            check_value("ar.size", 32'(slave.size_log[i]), 32'd2);
            check_value("ar.id", 32'(slave.id_log[i]), 32'd0);
        end
    endtask

    task automatic test_sequential();
        fetch_and_check(RESET_PC, 8);
        check_requests(0, 8, 8'd0, BURST_FIXED);
    endtask

    task automatic test_reuse();
        redirect_to(RESET_PC);
        fetch_and_check(RESET_PC, 8);
        check_value("ar_count", 32'(ar_count), 32'd8);
    endtask

    task automatic test_sdram_burst();
        int base;
        base = ar_count;
        redirect_to(32'hA000_0020);
        fetch_and_check(32'hA000_0020, 4);
        check_requests(base, 1, 8'd3, BURST_INCR);
    endtask

    task automatic test_redirect_drop();
        int base;
        base = ar_count;
        redirect_to(RESET_PC);
        fetch_and_check(RESET_PC, 1);
        // the word at RESET_PC + 4 hits in this cycle and has to be dropped
        idu_ready      = 1'b1;
        redirect_valid = 1'b1;
        redirect_pc    = RESET_PC + 32'h10;
        next_cycle();
        redirect_valid = 1'b0;
        check_value("inst_valid", 32'(inst_valid), 32'd0);
        fetch_and_check(RESET_PC + 32'h10, 2);
        check_value("ar_count", 32'(ar_count), 32'(base));
    endtask

    task automatic test_backpressure();
        redirect_to(RESET_PC);
        fetch_and_check(RESET_PC, 3);
        repeat (10) begin
            next_cycle();
            check_value("inst_valid", 32'(inst_valid), 32'd0);
            check_value("fetch_out.pc", fetch_out.pc, RESET_PC + 32'h8);
            check_value("fetch_out.inst", fetch_out.inst,
                        expected_inst(RESET_PC + 32'h8));
        end
        fetch_and_check(RESET_PC + 32'hC, 3);
    endtask

    task automatic test_access_fault();
        int base;
        base = ar_count;
        redirect_to(32'h3000_0100);
        fetch_and_check(32'h3000_0100, 8);
        check_requests(base, 8, 8'd0, BURST_FIXED);
    endtask

    initial begin
        rst            = 1'b1;
        idu_ready      = 1'b0;
        redirect_valid = 1'b0;
        redirect_pc    = '0;
        repeat (2) @(posedge clk);
        #1;
        rst = 1'b0;
        test_sequential();
        test_reuse();
        test_sdram_burst();
        test_redirect_drop();
        test_backpressure();
        test_access_fault();
        $display(">>> PASS");
        $finish;
    end

endmodule

`default_nettype wire

// ==== all.f ====
design/fetch_pkg.sv
design/axi_rd_pkg.sv
design/pc_gen.sv
design/fetch_ctrl.sv
design/icache.sv
design/axi_refill.sv
design/ifu_top.sv
verif/axi_mem_model.sv
verif/ifu_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f all.f --top-module ifu_tb -o ifu_sim \
    && ./obj_dir/ifu_sim | tee /dev/stderr | grep -x '>>> PASS' > /dev/null \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }
